// ==== verilog/pitch_pkg.sv ====
package pitch_pkg;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [15:0] sample_t;     // Unsigned audio sample
    typedef logic [9:0]  period_t;     // Period in samples, saturating
    typedef logic [3:0]  note_t;       // Pitch class index

    localparam int NUM_NOTES      = 12;
    localparam int NUM_OCTAVES    = 3;   // Octaves 4, 5 and 6
    localparam int NUM_WINDOWS    = NUM_NOTES * NUM_OCTAVES;
    localparam int STABLE_PERIODS = 4;

    // Run length of one repeated note, up to STABLE_PERIODS
    typedef logic [$clog2(STABLE_PERIODS + 1) - 1:0] run_count_t;

    localparam note_t NOTE_C    = 4'd0;
    localparam note_t NOTE_DS   = 4'd3;
    localparam note_t NOTE_E    = 4'd4;
    localparam note_t NOTE_G    = 4'd7;
    localparam note_t NOTE_NONE = 4'd12;

    localparam sample_t     CROSS_LEVEL    = 16'h8000;
    localparam int unsigned SAMPLE_RATE_HZ = 48000;
    localparam period_t     PERIOD_MAX     = '1;

    // ----------------------------------------
    // Pitch windows
    // ----------------------------------------

    // Octave 4 in hundredths of a hertz, C first
    localparam int unsigned FREQ_100_OCT4 [NUM_NOTES] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    typedef period_t window_table_t [NUM_WINDOWS];

    // Nominal period is SAMPLE_RATE_HZ * 100 / freq_100, so scaling it by
    // percent / 100 leaves SAMPLE_RATE_HZ * percent / freq_100.
    // Entry index is octave * 12 + pitch class, octave 4 first.
    function automatic window_table_t build_windows(input int unsigned percent);
        window_table_t bounds;
        int unsigned   freq_100;

        for (int oct = 0; oct < NUM_OCTAVES; oct++)
        begin
            for (int n = 0; n < NUM_NOTES; n++)
            begin
                freq_100 = FREQ_100_OCT4[n] << oct;   // One octave up doubles it
                bounds[oct * NUM_NOTES + n] =
                    period_t'(SAMPLE_RATE_HZ * percent / freq_100);
            end
        end
        return bounds;
    endfunction

    localparam window_table_t PERIOD_LOW  = build_windows(97);
    localparam window_table_t PERIOD_HIGH = build_windows(103);

endpackage

// ==== verilog/display_pkg.sv ====
package display_pkg;

    // ----------------------------------------
    // Chord tracking
    // ----------------------------------------

    typedef enum logic [1:0]
    {
        CHORD_NONE    = 2'd0,
        CHORD_C_MAJOR = 2'd1,
        CHORD_C_MINOR = 2'd2
    } chord_t;

    typedef enum logic [2:0]
    {
        WAIT_C       = 3'd0,
        WAIT_THIRD   = 3'd1,   // E for major, D# for minor
        WAIT_G_MAJOR = 3'd2,
        WAIT_G_MINOR = 3'd3,
        C_MAJOR      = 3'd4,
        C_MINOR      = 3'd5
    } tracker_state_t;

    // ----------------------------------------
    // Seven-segment, abcdefgh, active low
    // ----------------------------------------

    typedef logic [7:0] segments_t;

    localparam segments_t SEG_BLANK = 8'b1111_1111;

    // Sharps reuse the letter with the dot lit
    localparam segments_t SEG_TABLE [12] = '{
        8'b0110_0011, 8'b0110_0010,   // C  C#
        8'b1000_0101, 8'b1000_0100,   // D  D#
        8'b0110_0001,                 // E
        8'b0111_0001, 8'b0111_0000,   // F  F#
        8'b0100_0011, 8'b0100_0010,   // G  G#
        8'b0001_0001, 8'b0001_0000,   // A  A#
        8'b1100_0001                  // B
    };

endpackage

// ==== verilog/period_meter.sv ====
`timescale 1ns/100ps

module period_meter
(
    input  logic               clk,
    input  logic               reset,
    input  pitch_pkg::sample_t sample,
    input  logic               sample_valid,
    output pitch_pkg::period_t period,
    output logic               period_valid
);

    import pitch_pkg::*;

    sample_t prev_sample;   // Last valid sample
    period_t count;         // Valid samples since last crossing
    logic    armed;         // First crossing seen
    logic    crossing;

    // Upward crossing of the fixed level
    assign crossing = sample_valid
                   && sample > CROSS_LEVEL
                   && prev_sample < CROSS_LEVEL;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_sample  <= CROSS_LEVEL;   // Neither below nor above
            count        <= '0;
            armed        <= 1'b0;
            period_valid <= 1'b0;
        end
        else
        begin
            period_valid <= crossing && armed;

            if (sample_valid)
            begin
                prev_sample <= sample;

                if (crossing)
                begin
                    count <= period_t'(1);   // Crossing sample opens the next period
                    armed <= 1'b1;
                end
                else if (count != PERIOD_MAX)
                    count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
        if (crossing)
            period <= count;

    // The first crossing only starts the count
    assert property (@(posedge clk) disable iff (reset) period_valid |-> period != '0)
        else $error("period_valid raised with a zero period");

endmodule

// ==== verilog/note_decoder.sv ====
`timescale 1ns/100ps

module note_decoder
(
    input  logic               clk,
    input  logic               reset,
    input  pitch_pkg::period_t period,
    input  logic               period_valid,
    output pitch_pkg::note_t   note,
    output logic               note_valid
);

    import pitch_pkg::*;

    logic [NUM_WINDOWS - 1:0] window_hit;   // One per note and octave
    logic [NUM_NOTES - 1:0]   class_hit;    // Octaves folded
    note_t                    match_note;

    always_comb
    begin
        for (int i = 0; i < NUM_WINDOWS; i++)
            window_hit[i] = period > PERIOD_LOW[i] && period < PERIOD_HIGH[i];
    end

    // ----------------------------------------
    // Fold octaves onto the pitch class
    // ----------------------------------------

    always_comb
    begin
        class_hit  = '0;
        match_note = NOTE_NONE;

        for (int n = 0; n < NUM_NOTES; n++)
        begin
            for (int oct = 0; oct < NUM_OCTAVES; oct++)
                class_hit[n] = class_hit[n] | window_hit[oct * NUM_NOTES + n];

            if (class_hit[n])
                match_note = note_t'(n);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            note_valid <= 1'b0;
        else
            note_valid <= period_valid;
    end

    always_ff @(posedge clk)
        if (period_valid)
            note <= match_note;

    // Windows of the package tables must be disjoint
    assert property (@(posedge clk) disable iff (reset) period_valid |-> $onehot0(class_hit))
        else $error("period %0d matches more than one pitch class", period);

endmodule

// ==== verilog/chord_tracker.sv ====
`timescale 1ns/100ps

module chord_tracker
(
    input  logic                clk,
    input  logic                reset,
    input  pitch_pkg::note_t    note,
    input  logic                note_valid,
    output pitch_pkg::note_t    stable_note,
    output display_pkg::chord_t chord
);

    import pitch_pkg::*;
    import display_pkg::*;

    note_t          last_note;
    run_count_t     run_count;        // Equal pulses in a row
    logic           same_note;
    logic           promote;
    logic           stable_changed;   // Pulse one cycle after stable_note moves
    tracker_state_t state;
    tracker_state_t next_state;

    assign same_note = note == last_note;

    // Fires on exactly the STABLE_PERIODS-th equal period
    assign promote = note_valid && same_note
                  && run_count == run_count_t'(STABLE_PERIODS - 1)
                  && note != stable_note;

    // ----------------------------------------
    // Stability filter
    // ----------------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            last_note      <= NOTE_NONE;
            run_count      <= '0;
            stable_note    <= NOTE_NONE;
            stable_changed <= 1'b0;
        end
        else
        begin
            stable_changed <= promote;

            if (promote)
                stable_note <= note;

            if (note_valid)
            begin
                if (!same_note)
                begin
                    last_note <= note;
                    run_count <= run_count_t'(1);
                end
                else if (run_count != run_count_t'(STABLE_PERIODS))
                    run_count <= run_count + 1'b1;   // Saturates
            end
        end
    end

    // ----------------------------------------
    // Triad FSM
    // ----------------------------------------

    always_comb
    begin
        next_state = state;

        if (stable_changed)
        begin
            case (state)
                WAIT_C:
                    if (stable_note == NOTE_C)
                        next_state = WAIT_THIRD;
                WAIT_THIRD:
                    if (stable_note == NOTE_E)
                        next_state = WAIT_G_MAJOR;
                    else if (stable_note == NOTE_DS)
                        next_state = WAIT_G_MINOR;
                WAIT_G_MAJOR:
                    if (stable_note == NOTE_G)
                        next_state = C_MAJOR;
                WAIT_G_MINOR:
                    if (stable_note == NOTE_G)
                        next_state = C_MINOR;
                C_MAJOR, C_MINOR:
                    if (stable_note == NOTE_C)
                        next_state = WAIT_THIRD;   // New root starts over
                default:
                    next_state = WAIT_C;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= WAIT_C;
        else
            state <= next_state;
    end

    always_comb
    begin
        case (state)
            C_MAJOR: chord = CHORD_C_MAJOR;
            C_MINOR: chord = CHORD_C_MINOR;
            default: chord = CHORD_NONE;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        state inside {WAIT_C, WAIT_THIRD, WAIT_G_MAJOR, WAIT_G_MINOR, C_MAJOR, C_MINOR})
        else $error("chord tracker in illegal state %0d", state);

endmodule

// ==== verilog/note_display.sv ====
`timescale 1ns/100ps

module note_display
(
    input  logic                   clk,
    input  logic                   reset,
    input  pitch_pkg::note_t       stable_note,
    output display_pkg::segments_t abcdefgh
);

    import pitch_pkg::*;
    import display_pkg::*;

    //    --a--
    //   f     b
    //    --g--
    //   e     c
    //    --d--  h

    // Registered so the pins never glitch
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            abcdefgh <= SEG_BLANK;
        else if (stable_note < NOTE_NONE)
            abcdefgh <= SEG_TABLE[stable_note];
        else
            abcdefgh <= SEG_BLANK;   // No note, all segments off
    end

endmodule

// ==== verilog/note_recognizer_top.sv ====
`timescale 1ns/100ps

module note_recognizer_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  pitch_pkg::sample_t     sample,
    input  logic                   sample_valid,
    output pitch_pkg::note_t       stable_note,
    output display_pkg::chord_t    chord,
    output display_pkg::segments_t abcdefgh
);

    import pitch_pkg::*;

    period_t period;
    logic    period_valid;
    note_t   note;
    logic    note_valid;

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    period_meter u_period_meter
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .period       ( period       ),
        .period_valid ( period_valid )
    );

    note_decoder u_note_decoder
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .period       ( period       ),
        .period_valid ( period_valid ),
        .note         ( note         ),
        .note_valid   ( note_valid   )
    );

    // ----------------------------------------
    // Execute and result
    // ----------------------------------------

    chord_tracker u_chord_tracker
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .note        ( note        ),
        .note_valid  ( note_valid  ),
        .stable_note ( stable_note ),
        .chord       ( chord       )
    );

    note_display u_note_display
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .stable_note ( stable_note ),
        .abcdefgh    ( abcdefgh    )
    );

endmodule

// ==== verification/tb_note_recognizer.sv ====
`timescale 1ns/100ps

module tb_note_recognizer;

    import pitch_pkg::*;
    import display_pkg::*;

    localparam int MAX_TESTS    = 64;
    localparam int MAX_TONES    = 256;
    localparam int DRAIN_CYCLES = 8;   // Last crossing to stable_note, with margin
    localparam     TEST_FILE    = "verification/note_tests.txt";

    logic      clk;
    logic      reset;
    sample_t   sample;
    logic      sample_valid;
    note_t     stable_note;
    chord_t    chord;
    segments_t abcdefgh;

    // Test table, filled from the data file
    string test_name [MAX_TESTS];
    int    tone_first [MAX_TESTS];
    int    tone_count [MAX_TESTS];
    int    exp_note [MAX_TESTS];
    int    exp_chord [MAX_TESTS];
    int    tone_period [MAX_TONES];
    int    tone_repeat [MAX_TONES];

    int     num_tests;
    int     num_tones;
    int     watchdog_cycles;   // Zero until the file is read
    int     pass_count;
    int     fail_count;
    bit     tests_loaded;
    integer seed;

    note_recognizer_top u_note_recognizer_top
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .stable_note  ( stable_note  ),
        .chord        ( chord        ),
        .abcdefgh     ( abcdefgh     )
    );

    always #4 clk = ~clk;   // 8 ns period

    // ----------------------------------------
    // Data file
    // ----------------------------------------

    task automatic load_tests(output bit ok);
        int    fd;
        int    ch;
        int    code;
        int    count;
        int    total;
        bit    parsed;
        string name;
        ok        = 1'b0;
        parsed    = 1'b1;
        num_tests = 0;
        num_tones = 0;
        total     = 0;
        fd        = $fopen(TEST_FILE, "r");
        if (fd != 0)
        begin
            while ($fscanf(fd, "%s", name) == 1)
            begin
                if (name[0] == "#")
                begin
                    ch = 0;
                    while (ch != "\n" && ch != -1)
                        ch = $fgetc(fd);   // Skip the rest of a comment line
                end
                else
                begin
                    code   = $fscanf(fd, "%d", count);
                    parsed = parsed && code == 1;
                    test_name[num_tests]  = name;
                    tone_first[num_tests] = num_tones;
                    tone_count[num_tests] = count;
                    for (int i = 0; i < count; i++)
                    begin
                        code = $fscanf(fd, "%d %d", tone_period[num_tones],
                                       tone_repeat[num_tones]);
                        parsed = parsed && code == 2;
                        total += tone_period[num_tones] * tone_repeat[num_tones];
                        num_tones++;
                    end
                    code   = $fscanf(fd, "%d %d", exp_note[num_tests], exp_chord[num_tests]);
                    parsed = parsed && code == 2;
                    num_tests++;
                end
            end
            $fclose(fd);
            watchdog_cycles = total * 3 + 1000;   // At most 3 cycles per sample
            ok = parsed && num_tests > 0;
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic send_sample(input sample_t value);
        int gap;
        gap = $unsigned($random(seed)) % 3;   // 0 to 2 idle cycles
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
        sample       = value;
        sample_valid = 1'b1;
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    // Low half first, so each period starts its upward crossing mid-way
    task automatic play_tone(input int period, input int repeats);
        for (int r = 0; r < repeats; r++)
        begin
            for (int i = 0; i < period - period / 2; i++)
                send_sample(16'h2000);
            for (int i = 0; i < period / 2; i++)
                send_sample(16'hE000);
        end
    endtask

    task automatic wait_settled(input note_t expected);
        int cycles;
        cycles = 0;
        while (stable_note !== expected && cycles < DRAIN_CYCLES)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        // Chord state and display trail stable_note by one cycle each
        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_result(input int t);
        segments_t exp_seg;
        int        errors;
        errors  = 0;
        exp_seg = (exp_note[t] < NOTE_NONE) ? SEG_TABLE[exp_note[t]] : SEG_BLANK;
        if (stable_note !== note_t'(exp_note[t]))
        begin
            $display("Error %s stable_note expected %0d actual %0d",
                     test_name[t], exp_note[t], stable_note);
            errors++;
        end
        if (chord !== chord_t'(exp_chord[t]))
        begin
            $display("Error %s chord expected %0d actual %0d", test_name[t], exp_chord[t], chord);
            errors++;
        end
        if (abcdefgh !== exp_seg)
        begin
            $display("Error %s abcdefgh expected %b actual %b", test_name[t], exp_seg, abcdefgh);
            errors++;
        end
        if (errors == 0)
        begin
            pass_count++;
            $display("%s: ok", test_name[t]);
        end
        else
        begin
            fail_count++;
            $display("%s: %0d mismatches", test_name[t], errors);
        end
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        sample       = '0;
        sample_valid = 1'b0;
        seed         = 16829;
        pass_count   = 0;
        fail_count   = 0;
        load_tests(tests_loaded);
        if (!tests_loaded)
        begin
            $display("Could not read the tests from %s", TEST_FILE);
            $display("test failed");
            $finish;
        end
        else
        begin
            repeat (10) @(posedge clk);
            #1;
            reset = 1'b0;
            for (int t = 0; t < num_tests; t++)
            begin
                for (int k = 0; k < tone_count[t]; k++)
                    play_tone(tone_period[tone_first[t] + k], tone_repeat[tone_first[t] + k]);
                wait_settled(note_t'(exp_note[t]));
                check_result(t);
            end
            $display("Summary: %0d tests, %0d passed, %0d failed",
                     num_tests, pass_count, fail_count);
            if (fail_count == 0)
                $display("test passed");
            else
                $display("test failed");
            $finish;
        end
    end

    initial
    begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

endmodule

// ==== verification/note_tests.txt ====
# name  tone_count  then period repeat for each tone  then stable_note chord
# Periods in samples, note 0 = C to 11 = B and 12 = none, chord 0 none, 1 major, 2 minor
reset_idle      0                             12 0
c_major         3  183 8  146 8  122 8         7 1
c_minor         3  183 8  154 8  122 8         7 2
c_f_g           3  183 8  137 8  122 8         7 0
oct4_c          1  183 8                       0 0
oct4_cs         1  173 8                       1 0
oct4_d          1  163 8                       2 0
oct4_ds         1  154 8                       3 0
oct4_e          1  146 8                       4 0
oct4_f          1  137 8                       5 0
oct4_fs         1  130 8                       6 0
oct4_g          1  122 8                       7 2
oct4_gs         1  116 8                       8 2
oct4_a          1  109 8                       9 2
oct4_as         1  103 8                      10 2
oct4_b          1   97 8                      11 2
oct5_c          1   92 8                       0 0
oct5_e          1   73 8                       4 0
oct5_a          1   55 8                       9 0
oct6_c          1   46 8                       0 0
oct6_e          1   36 8                       4 0
oct6_a          1   27 8                       9 0
no_window       1  300 8                      12 0
short_tone      2  146 8  109 3                4 0
g_after_short   1  122 8                       7 1

// ==== sources.f ====
verilog/pitch_pkg.sv
verilog/display_pkg.sv
verilog/period_meter.sv
verilog/note_decoder.sv
verilog/chord_tracker.sv
verilog/note_display.sv
verilog/note_recognizer_top.sv
verification/tb_note_recognizer.sv

// ==== Bender.yml ====
package:
  name: note_recognizer

sources:
  - verilog/pitch_pkg.sv
  - verilog/display_pkg.sv
  - verilog/period_meter.sv
  - verilog/note_decoder.sv
  - verilog/chord_tracker.sv
  - verilog/note_display.sv
  - verilog/note_recognizer_top.sv
  - target: test
    files:
      - verification/tb_note_recognizer.sv
